// File: source/video_pkg.sv
// pixel format and frame geometry for the stream side of the frame buffer
// modules take it with a wildcard import in the body
// and use scoped names in their port lists
package video_pkg;

    // one rgb pixel, 8 bits per channel
    typedef logic [23:0] pixel_t;

    // fixed geometry, nothing is configured at run time
    // both sizes are powers of two so position counters wrap by themselves
    localparam int H_ACTIVE     = 16;
    localparam int V_ACTIVE     = 4;

    // pixels in one whole frame
    localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;

endpackage

// File: source/mem_bus_pkg.sv
// word format, address layout and sizes of the on-chip frame memory
// shared by the writer, the reader, the memory and the bus interface
package mem_bus_pkg;

    // combine and destruct stages work on four pixels at a time
    localparam int PIXELS_PER_WORD = 4;

    // pixel 0 sits in the lowest bits
    typedef logic [PIXELS_PER_WORD*$bits(video_pkg::pixel_t)-1:0] word_t;

    // one frame fills a slot exactly
    localparam int WORDS_PER_FRAME = video_pkg::FRAME_PIXELS / PIXELS_PER_WORD;

    // two slots, one being filled while the other drains
    localparam int NUM_SLOTS       = 2;
    localparam int MEM_DEPTH       = NUM_SLOTS * WORDS_PER_FRAME;

    // msb picks the slot, the low bits index the word inside it
    // so a plain increment steps through a slot and then flips to the other
    typedef logic [$clog2(MEM_DEPTH)-1:0] addr_t;

    // depth of every stream fifo, words on the write side and pixels on the read side
    localparam int FIFO_DEPTH      = 4;

endpackage

// File: source/mem_bus_if.sv
`timescale 1ns/1ns
// apb-style word bus between writer, reader, arbiter and frame memory
// setup cycle has sel alone, access cycle has sel and enable,
// the transfer ends in the access cycle where ready is high
interface mem_bus_if;
    import mem_bus_pkg::*;

    addr_t addr;
    logic  write;
    word_t wdata;
    word_t rdata;
    logic  sel;
    logic  enable;
    logic  ready;

    // address phase and write data come from the requester
    modport requester (
        output addr, write, wdata, sel, enable,
        input  rdata, ready
    );

    // completer answers with read data and ready
    modport completer (
        input  addr, write, wdata, sel, enable,
        output rdata, ready
    );

endinterface

// File: source/stream_fifo.sv
`timescale 1ns/1ns
// small synchronous fifo on a circular buffer
// payload is a type parameter, used for packed words and for single pixels
// pop_data shows the head entry, count gives the fill level
module stream_fifo #(
    parameter type payload_t = logic
) (
    input  logic                                   mm_tras_inst,
    input  logic                                   rst_n,
    input  logic                                   push,
    input  payload_t                               push_data,
    output logic                                   full,
    input  logic                                   pop,
    output payload_t                               pop_data,
    output logic                                   empty,
    output logic [$clog2(mem_bus_pkg::FIFO_DEPTH):0] count
);
    import mem_bus_pkg::*;

    payload_t                      buf_q [FIFO_DEPTH];
    // depth is a power of two, pointers wrap on overflow
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic                          do_push;
    logic                          do_pop;

    // push into full and pop from empty are dropped
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;

    // count tops out at FIFO_DEPTH, only then is its msb set
    assign full     = count[$clog2(FIFO_DEPTH)];
    assign empty    = (count == '0);
    assign pop_data = buf_q[rd_ptr];

    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // level moves only when one side acts alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge mm_tras_inst) begin
        if (do_push)
            buf_q[wr_ptr] <= push_data;
    end

endmodule

// File: source/frame_writer.sv
`timescale 1ns/1ns
// write side of the frame buffer
// packs four accepted pixels into one word, queues it, writes the fifo head
// to the current slot over the memory bus and owns the slot occupancy count
module frame_writer (
    input  logic              mm_tras_inst,
    input  logic              rst_n,
    input  video_pkg::pixel_t in_pixel,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic              frame_consumed,
    output logic              frame_avail,
    mem_bus_if.requester      bus
);
    import video_pkg::*;
    import mem_bus_pkg::*;

    typedef logic [$clog2(NUM_SLOTS):0] occ_t;

    // pixel position inside the incoming frame
    logic [$clog2(FRAME_PIXELS)-1:0] in_cnt;
    logic                            run_q;
    logic                            in_fire;
    word_t                           pack_q;
    logic                            push_q;
    logic                            fifo_full;
    logic                            fifo_empty;
    word_t                           fifo_head;
    // slot bit on top, word index below
    addr_t                           wr_addr;
    logic                            wr_done;
    logic                            frame_done;
    occ_t                            occ_cnt;
    logic                            slots_full;

    assign slots_full  = (occ_cnt == occ_t'(NUM_SLOTS));
    assign frame_avail = (occ_cnt != '0);

    // first cycle after reset blocked by run_q
    // a new frame waits while both slots hold unread frames
    assign in_ready = run_q && !fifo_full && !((in_cnt == '0) && slots_full);
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            in_cnt <= '0;
            push_q <= 1'b0;
        end else begin
            run_q  <= 1'b1;
            // word leaves the combine stage one cycle after its fourth pixel
            push_q <= in_fire && (&in_cnt[$clog2(PIXELS_PER_WORD)-1:0]);
            if (in_fire)
                in_cnt <= in_cnt + 1'b1;
        end
    end

    // combine stage, new pixels shift in from the top so pixel 0 ends lowest
    always_ff @(posedge mm_tras_inst) begin
        if (in_fire)
            pack_q <= {in_pixel, pack_q[$bits(word_t)-1:$bits(pixel_t)]};
    end

    stream_fifo #(
        .payload_t (word_t)
    ) u_word_fifo (
        .mm_tras_inst (mm_tras_inst),
        .rst_n        (rst_n),
        .push         (push_q),
        .push_data    (pack_q),
        .full         (fifo_full),
        .pop          (wr_done),
        .pop_data     (fifo_head),
        .empty        (fifo_empty),
        .count        ()
    );

    // fifo head and address stay put until the transfer completes
    assign bus.addr  = wr_addr;
    assign bus.write = 1'b1;
    assign bus.wdata = fifo_head;

    assign wr_done    = bus.sel && bus.enable && bus.ready;
    assign frame_done = wr_done && (&wr_addr[$bits(addr_t)-2:0]);

    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n) begin
            bus.sel    <= 1'b0;
            bus.enable <= 1'b0;
            wr_addr    <= '0;
            occ_cnt    <= '0;
        end else begin
            // start only when the current slot is free
            if (!bus.sel) begin
                bus.sel <= !fifo_empty && !slots_full;
            end else if (!bus.enable) begin
                bus.enable <= 1'b1;
            end else if (bus.ready) begin
                bus.sel    <= 1'b0;
                bus.enable <= 1'b0;
                // last word of a slot carries into the slot bit
                wr_addr    <= wr_addr + 1'b1;
            end
            // whole frames written minus frames consumed by the reader
            case ({frame_done, frame_consumed})
                2'b10:   occ_cnt <= occ_cnt + 1'b1;
                2'b01:   occ_cnt <= occ_cnt - 1'b1;
                default: occ_cnt <= occ_cnt;
            endcase
        end
    end

endmodule

// File: source/frame_reader.sv
`timescale 1ns/1ns
// read side of the frame buffer
// fetches the words of each full slot in order, unpacks them into a
// pixel fifo and sends the pixels out with sof and eol rebuilt from position
module frame_reader (
    input  logic              mm_tras_inst,
    input  logic              rst_n,
    input  logic              frame_avail,
    output logic              frame_consumed,
    mem_bus_if.requester      bus,
    output video_pkg::pixel_t out_pixel,
    output logic              out_sof,
    output logic              out_eol,
    output logic              out_valid,
    input  logic              out_ready
);
    import video_pkg::*;
    import mem_bus_pkg::*;

    typedef logic [$clog2(FIFO_DEPTH):0] level_t;

    // slot bit on top, word index below
    addr_t                              rd_addr;
    logic                               rd_done;
    word_t                              unpack_q;
    logic [$clog2(PIXELS_PER_WORD)-1:0] upk_idx;
    logic                               upk_busy;
    logic                               fifo_empty;
    level_t                             fifo_count;
    logic                               room;
    logic                               out_fire;
    // output position, both wrap at the frame edge
    logic [$clog2(H_ACTIVE)-1:0]        col;
    logic [$clog2(V_ACTIVE)-1:0]        line;

    // a fetch needs space for every pixel of the word
    assign room = (level_t'(FIFO_DEPTH) - fifo_count) >= level_t'(PIXELS_PER_WORD);

    assign bus.addr  = rd_addr;
    assign bus.write = 1'b0;
    assign bus.wdata = '0;
    assign rd_done   = bus.sel && bus.enable && bus.ready;

    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n) begin
            bus.sel        <= 1'b0;
            bus.enable     <= 1'b0;
            rd_addr        <= '0;
            frame_consumed <= 1'b0;
            upk_busy       <= 1'b0;
            upk_idx        <= '0;
        end else begin
            // pulse once the last word of the slot is in
            frame_consumed <= rd_done && (&rd_addr[$bits(addr_t)-2:0]);
            if (!bus.sel) begin
                bus.sel <= frame_avail && !upk_busy && room;
            end else if (!bus.enable) begin
                bus.enable <= 1'b1;
            end else if (bus.ready) begin
                bus.sel    <= 1'b0;
                bus.enable <= 1'b0;
                // carry out of the word index flips the slot
                rd_addr    <= rd_addr + 1'b1;
            end
            // destruct stage, one pixel per cycle
            // stays busy long enough for the writer to see frame_consumed
            if (rd_done) begin
                upk_busy <= 1'b1;
                upk_idx  <= '0;
            end else if (upk_busy) begin
                upk_idx <= upk_idx + 1'b1;
                if (&upk_idx)
                    upk_busy <= 1'b0;
            end
        end
    end

    // word shifts down so the next pixel is always in the low bits
    always_ff @(posedge mm_tras_inst) begin
        if (rd_done)
            unpack_q <= bus.rdata;
        else if (upk_busy)
            unpack_q <= unpack_q >> $bits(pixel_t);
    end

    stream_fifo #(
        .payload_t (pixel_t)
    ) u_pixel_fifo (
        .mm_tras_inst (mm_tras_inst),
        .rst_n        (rst_n),
        .push         (upk_busy),
        .push_data    (unpack_q[$bits(pixel_t)-1:0]),
        .full         (),
        .pop          (out_fire),
        .pop_data     (out_pixel),
        .empty        (fifo_empty),
        .count        (fifo_count)
    );

    // output holds while out_ready is low
    assign out_valid = !fifo_empty;
    assign out_fire  = out_valid && out_ready;
    assign out_sof   = (col == '0) && (line == '0);
    assign out_eol   = &col;

    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n) begin
            col  <= '0;
            line <= '0;
        end else if (out_fire) begin
            col <= col + 1'b1;
            if (&col)
                line <= line + 1'b1;
        end
    end

endmodule

// File: source/bus_arbiter.sv
`timescale 1ns/1ns
// round-robin arbiter between frame writer and frame reader
// one requester at a time is passed through to the memory bus, the grant
// locks from the memory setup cycle until ready ends the transfer
module bus_arbiter (
    input  logic         mm_tras_inst,
    input  logic         rst_n,
    mem_bus_if.completer writer_bus,
    mem_bus_if.completer reader_bus,
    mem_bus_if.requester mem_bus
);

    logic busy_q;
    logic grant_q;
    logic last_rd_q;
    logic pick_rd;
    logic grant_rd;
    logic xfer_done;

    // reader wins when alone, or on a tie when the writer was served last
    assign pick_rd  = reader_bus.sel && (!writer_bus.sel || !last_rd_q);
    assign grant_rd = busy_q ? grant_q : pick_rd;

    // decision cycle shows sel alone to the memory
    // a requester that waited may already hold enable, it passes only once locked
    assign mem_bus.sel    = grant_rd ? reader_bus.sel : writer_bus.sel;
    assign mem_bus.enable = busy_q && (grant_rd ? reader_bus.enable : writer_bus.enable);
    assign mem_bus.addr   = grant_rd ? reader_bus.addr : writer_bus.addr;
    assign mem_bus.write  = grant_rd ? reader_bus.write : writer_bus.write;
    assign mem_bus.wdata  = grant_rd ? reader_bus.wdata : writer_bus.wdata;

    // side without grant sees ready low and waits
    assign reader_bus.ready = grant_rd && mem_bus.ready;
    assign writer_bus.ready = !grant_rd && mem_bus.ready;
    assign reader_bus.rdata = grant_rd ? mem_bus.rdata : '0;
    assign writer_bus.rdata = grant_rd ? '0 : mem_bus.rdata;

    assign xfer_done = mem_bus.sel && mem_bus.enable && mem_bus.ready;

    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            grant_q   <= 1'b0;
            last_rd_q <= 1'b0;
        end else if (!busy_q) begin
            if (writer_bus.sel || reader_bus.sel) begin
                busy_q  <= 1'b1;
                grant_q <= pick_rd;
            end
        end else if (xfer_done) begin
            busy_q    <= 1'b0;
            last_rd_q <= grant_q;
        end
    end

endmodule

// File: source/frame_mem.sv
`timescale 1ns/1ns
// on-chip frame memory holding both frame slots
// apb completer, read data is registered in setup and valid in access,
// every transfer takes exactly two cycles
module frame_mem (
    input  logic         mm_tras_inst,
    input  logic         rst_n,
    mem_bus_if.completer bus
);
    import mem_bus_pkg::*;

    word_t mem_q [MEM_DEPTH];
    logic  setup;

    assign setup = bus.sel && !bus.enable;

    // ready follows every setup, so it lands on the access cycle
    always_ff @(posedge mm_tras_inst) begin
        if (!rst_n)
            bus.ready <= 1'b0;
        else
            bus.ready <= setup;
    end

    always_ff @(posedge mm_tras_inst) begin
        if (setup && !bus.write)
            bus.rdata <= mem_q[bus.addr];
        // write lands in the access cycle
        if (bus.sel && bus.enable && bus.write)
            mem_q[bus.addr] <= bus.wdata;
    end

endmodule

// File: source/frame_buffer_top.sv
`timescale 1ns/1ns
// two-slot video frame buffer, top level
// pixel stream in, whole frames stored on chip, same stream out
// both streams use valid and ready, out_sof and out_eol come from position
module frame_buffer_top (
    input  logic              mm_tras_inst,
    input  logic              rst_n,
    input  video_pkg::pixel_t in_pixel,
    input  logic              in_sof,
    input  logic              in_eol,
    input  logic              in_valid,
    output logic              in_ready,
    output video_pkg::pixel_t out_pixel,
    output logic              out_sof,
    output logic              out_eol,
    output logic              out_valid,
    input  logic              out_ready
);

    // slot handshake between the two sides
    logic frame_avail;
    logic frame_consumed;

    mem_bus_if writer_bus ();
    mem_bus_if reader_bus ();
    mem_bus_if mem_bus ();

    // in_sof and in_eol are taken with the beat, framing is fixed by geometry
    frame_writer u_writer (
        .mm_tras_inst   (mm_tras_inst),
        .rst_n          (rst_n),
        .in_pixel       (in_pixel),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .frame_consumed (frame_consumed),
        .frame_avail    (frame_avail),
        .bus            (writer_bus.requester)
    );

    frame_reader u_reader (
        .mm_tras_inst   (mm_tras_inst),
        .rst_n          (rst_n),
        .frame_avail    (frame_avail),
        .frame_consumed (frame_consumed),
        .bus            (reader_bus.requester),
        .out_pixel      (out_pixel),
        .out_sof        (out_sof),
        .out_eol        (out_eol),
        .out_valid      (out_valid),
        .out_ready      (out_ready)
    );

    bus_arbiter u_arbiter (
        .mm_tras_inst (mm_tras_inst),
        .rst_n        (rst_n),
        .writer_bus   (writer_bus.completer),
        .reader_bus   (reader_bus.completer),
        .mem_bus      (mem_bus.requester)
    );

    frame_mem u_mem (
        .mm_tras_inst (mm_tras_inst),
        .rst_n        (rst_n),
        .bus          (mem_bus.completer)
    );

endmodule

// File: tb/frame_buffer_properties.sv
`timescale 1ns/1ns
// memory bus protocol checks on the arbiter's memory side
// bound into bus_arbiter so every instance of it gets these assertions
module frame_buffer_properties (
    input logic                mm_tras_inst,
    input logic                rst_n,
    input logic                sel,
    input logic                enable,
    input logic                ready,
    input logic                write,
    input mem_bus_pkg::addr_t  addr,
    input mem_bus_pkg::word_t  wdata,
    input logic                writer_sel,
    input logic                writer_enable,
    input logic                writer_ready,
    input logic                reader_sel,
    input logic                reader_enable,
    input logic                reader_ready
);

    // enable never stands without sel
    a_enable_needs_sel: assert property (@(posedge mm_tras_inst) disable iff (!rst_n)
        enable |-> sel)
        else $error("enable high while sel is low");

    // access follows a setup cycle with sel alone
    a_setup_first: assert property (@(posedge mm_tras_inst) disable iff (!rst_n)
        $rose(enable) |-> $past(sel))
        else $error("enable rose without a setup cycle");

    // address phase held until the completing access cycle
    a_stable_until_ready: assert property (@(posedge mm_tras_inst) disable iff (!rst_n)
        (sel && !(enable && ready)) |=> ($stable(addr) && $stable(write) && $stable(wdata)))
        else $error("addr, write or wdata changed before ready");

    a_ready_in_access: assert property (@(posedge mm_tras_inst) disable iff (!rst_n)
        ready |-> (sel && enable))
        else $error("ready outside an access cycle");

    // ready goes back only to the side whose own access cycle it ends
    a_ready_to_owner: assert property (@(posedge mm_tras_inst) disable iff (!rst_n)
        (writer_ready || reader_ready) |->
            (writer_ready ? (writer_sel && writer_enable) : (reader_sel && reader_enable)))
        else $error("ready returned to a requester outside its access cycle");

endmodule

bind bus_arbiter frame_buffer_properties u_bus_checks (
    .mm_tras_inst  (mm_tras_inst),
    .rst_n         (rst_n),
    .sel           (mem_bus.sel),
    .enable        (mem_bus.enable),
    .ready         (mem_bus.ready),
    .write         (mem_bus.write),
    .addr          (mem_bus.addr),
    .wdata         (mem_bus.wdata),
    .writer_sel    (writer_bus.sel),
    .writer_enable (writer_bus.enable),
    .writer_ready  (writer_bus.ready),
    .reader_sel    (reader_bus.sel),
    .reader_enable (reader_bus.enable),
    .reader_ready  (reader_bus.ready)
);

// File: tb/frame_buffer_tb.sv
`timescale 1ns/1ns
// testbench for the two-slot frame buffer
// sends five frames of lcg pixels with random valid and ready gaps,
// holds out_ready low for a long stretch in the middle,
// checks every output beat against a queue of accepted input pixels
module frame_buffer_tb;
    import video_pkg::*;
    import mem_bus_pkg::*;

    localparam int NUM_FRAMES   = 5;
    localparam int TOTAL_PIXELS = NUM_FRAMES * FRAME_PIXELS;
    // five frames at about 128 cycles each plus bus time, with a wide margin
    localparam int MAX_CYCLES   = 6000;
    // output stall window, cycles counted after reset
    localparam int STALL_START  = 100;
    localparam int STALL_END    = 500;
    // two stored frames, word fifo plus a partial word, and the pixel fifo
    localparam int MAX_HELD     = 2 * FRAME_PIXELS + (FIFO_DEPTH + 1) * PIXELS_PER_WORD
                                  + FIFO_DEPTH;

    logic        mm_tras_inst;
    logic        rst_n;
    pixel_t      in_pixel;
    logic        in_sof;
    logic        in_eol;
    logic        in_valid;
    logic        in_ready;
    pixel_t      out_pixel;
    logic        out_sof;
    logic        out_eol;
    logic        out_valid;
    logic        out_ready;

    logic [31:0] rng_state;
    // accepted pixels not yet seen at the output
    pixel_t      model_q [$];
    int          cycle;
    int          sent_cnt;
    int          recv_cnt;
    // input beat offered and not yet taken
    logic        pending;

    frame_buffer_top uut (
        .mm_tras_inst (mm_tras_inst),
        .rst_n        (rst_n),
        .in_pixel     (in_pixel),
        .in_sof       (in_sof),
        .in_eol       (in_eol),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_pixel    (out_pixel),
        .out_sof      (out_sof),
        .out_eol      (out_eol),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

    initial begin
        mm_tras_inst = 1'b0;
        forever #5 mm_tras_inst = ~mm_tras_inst;
    end

    // lcg, upper bits used since they have the longest period
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic halt_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        halt_run();
    endtask

    task automatic drive_out_ready();
        logic [31:0] r;
        r = next_random();
        if (cycle >= STALL_START && cycle < STALL_END)
            out_ready = 1'b0;
        else
            out_ready = (r[31:30] != 2'b00);
    endtask

    // a beat once offered is held until taken
    task automatic drive_input();
        logic [31:0] r;
        logic [31:0] p;
        if (!pending) begin
            r = next_random();
            p = next_random();
            if (sent_cnt < TOTAL_PIXELS && r[31:30] != 2'b00) begin
                pending  = 1'b1;
                in_valid = 1'b1;
                in_pixel = p[31:8];
                in_sof   = (sent_cnt % FRAME_PIXELS) == 0;
                in_eol   = (sent_cnt % H_ACTIVE) == H_ACTIVE - 1;
            end else begin
                in_valid = 1'b0;
            end
        end
    endtask

    // framing expected from output position alone
    task automatic check_output_beat();
        pixel_t exp_pixel;
        logic   exp_sof;
        logic   exp_eol;
        if (out_valid && out_ready) begin
            assert (model_q.size() > 0) else begin
                $display("ERROR: output beat %0d has no accepted input to match", recv_cnt);
                halt_run();
            end
            exp_pixel = model_q.pop_front();
            exp_sof   = (recv_cnt % FRAME_PIXELS) == 0;
            exp_eol   = (recv_cnt % H_ACTIVE) == H_ACTIVE - 1;
            assert (out_pixel == exp_pixel)
                else value_mismatch("out_pixel", 32'(out_pixel), 32'(exp_pixel));
            assert (out_sof == exp_sof)
                else value_mismatch("out_sof", 32'(out_sof), 32'(exp_sof));
            assert (out_eol == exp_eol)
                else value_mismatch("out_eol", 32'(out_eol), 32'(exp_eol));
            recv_cnt++;
        end
    endtask

    task automatic take_input_beat();
        if (in_valid && in_ready) begin
            model_q.push_back(in_pixel);
            sent_cnt++;
            pending = 1'b0;
            assert (model_q.size() <= MAX_HELD) else begin
                $display("ERROR: %0d pixels held inside the buffer, limit is %0d",
                         model_q.size(), MAX_HELD);
                halt_run();
            end
        end
    endtask

    // end of the long stall, both slots and fifos should be full
    task automatic check_stall();
        assert (in_ready == 1'b0)
            else value_mismatch("in_ready", 32'(in_ready), 32'd0);
        assert (model_q.size() >= 2 * FRAME_PIXELS) else begin
            $display("ERROR: input stopped with only %0d pixels held", model_q.size());
            halt_run();
        end
    endtask

    initial begin
        rng_state = 32'h11db;
        rst_n     = 1'b0;
        in_pixel  = '0;
        in_sof    = 1'b0;
        in_eol    = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        cycle     = 0;
        sent_cnt  = 0;
        recv_cnt  = 0;
        pending   = 1'b0;

        repeat (3) @(posedge mm_tras_inst);
        @(negedge mm_tras_inst);
        assert (out_valid == 1'b0)
            else value_mismatch("out_valid", 32'(out_valid), 32'd0);
        rst_n = 1'b1;
        // first cycle out of reset
        assert (in_ready == 1'b0)
            else value_mismatch("in_ready", 32'(in_ready), 32'd0);

        while (recv_cnt < TOTAL_PIXELS) begin
            @(negedge mm_tras_inst);
            cycle++;
            assert (cycle < MAX_CYCLES) else begin
                $display("ERROR: timeout after %0d cycles, %0d of %0d pixels came out",
                         cycle, recv_cnt, TOTAL_PIXELS);
                halt_run();
            end
            if (cycle == STALL_END)
                check_stall();
            drive_out_ready();
            drive_input();
            // output first, so a beat can never match input from the same edge
            check_output_beat();
            take_input_beat();
        end

        @(negedge mm_tras_inst);
        assert (model_q.size() == 0) else begin
            $display("ERROR: %0d accepted pixels never came out", model_q.size());
            halt_run();
        end
        assert (out_valid == 1'b0)
            else value_mismatch("out_valid", 32'(out_valid), 32'd0);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: flist.f
source/video_pkg.sv
source/mem_bus_pkg.sv
source/mem_bus_if.sv
source/stream_fifo.sv
source/frame_writer.sv
source/frame_reader.sv
source/bus_arbiter.sv
source/frame_mem.sv
source/frame_buffer_top.sv
tb/frame_buffer_properties.sv
tb/frame_buffer_tb.sv

// File: Makefile
TOP := frame_buffer_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then \
		echo "run failed, see sim.log"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log
